//--- alu/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  datapath_pkg::alu_ctrl_t ctrl,
	input  datapath_pkg::word_t     a,
	input  datapath_pkg::word_t     b,
	input  logic                    pass_a,
	input  logic                    pass_b,
	output datapath_pkg::exec_out_t out
);

	datapath_pkg::word_t sum;
	datapath_pkg::word_t diff;
	datapath_pkg::word_t neg;
	logic                sum_ovf;
	logic                diff_ovf;
	datapath_pkg::word_t and_out;
	datapath_pkg::word_t or_out;
	datapath_pkg::word_t not_out;
	datapath_pkg::word_t shl_out;
	datapath_pkg::word_t shr_out;

	alu_arith arith_i (
		.a        (a),
		.b        (b),
		.sum      (sum),
		.diff     (diff),
		.neg      (neg),
		.sum_ovf  (sum_ovf),
		.diff_ovf (diff_ovf)
	);

	alu_logic logic_i (
		.a       (a),
		.b       (b),
		.and_out (and_out),
		.or_out  (or_out),
		.not_out (not_out),
		.shl_out (shl_out),
		.shr_out (shr_out)
	);

	always_comb begin
		out = '0;
		case (ctrl.opcode)
			isa_pkg::OP_RTYPE: begin
				case (ctrl.func)
					isa_pkg::FN_ADD: begin
						out.result   = sum;
						out.overflow = sum_ovf;
					end
					isa_pkg::FN_SUB: begin
						out.result   = diff;
						out.overflow = diff_ovf;
					end
					isa_pkg::FN_AND: out.result = and_out;
					isa_pkg::FN_ORR: out.result = or_out;
					isa_pkg::FN_NOT: out.result = not_out;
					isa_pkg::FN_TCP: out.result = neg;
					isa_pkg::FN_SHL: out.result = shl_out;
					isa_pkg::FN_SHR: out.result = shr_out;
					isa_pkg::FN_JPR, isa_pkg::FN_JRL: out.result = a;
					default: out = '0;
				endcase
			end
			isa_pkg::OP_BNE: out.bcond = (a != b);
			isa_pkg::OP_BEQ: out.bcond = (a == b);
			isa_pkg::OP_BGZ: out.bcond = ($signed(a) > 0); // Strictly positive
			isa_pkg::OP_BLZ: out.bcond = ($signed(a) < 0);
			isa_pkg::OP_JMP, isa_pkg::OP_LHI: out.result = b;
			isa_pkg::OP_JAL: out.result = pass_a ? a : (pass_b ? b : '0);
			isa_pkg::OP_ADI, isa_pkg::OP_LWD, isa_pkg::OP_SWD: begin
				out.result   = sum;
				out.overflow = sum_ovf;
			end
			isa_pkg::OP_ORI: out.result = or_out;
			default: out = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- alu/alu_arith.sv
`timescale 1ns/1ps
`default_nettype none

module alu_arith (
	input  datapath_pkg::word_t a,
	input  datapath_pkg::word_t b,
	output datapath_pkg::word_t sum,
	output datapath_pkg::word_t diff,
	output datapath_pkg::word_t neg,
	output logic                sum_ovf,
	output logic                diff_ovf
);

	localparam int MSB = datapath_pkg::WORD_W - 1;

	assign sum  = a + b;
	assign diff = a - b;
	assign neg  = ~a + datapath_pkg::word_t'(1);

	// Like signs in, other sign out
	assign sum_ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);

	// Subtraction flips the sign test on b
	assign diff_ovf = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);

endmodule

`default_nettype wire

//--- alu/alu_logic.sv
`timescale 1ns/1ps
`default_nettype none

module alu_logic (
	input  datapath_pkg::word_t a,
	input  datapath_pkg::word_t b,
	output datapath_pkg::word_t and_out,
	output datapath_pkg::word_t or_out,
	output datapath_pkg::word_t not_out,
	output datapath_pkg::word_t shl_out,
	output datapath_pkg::word_t shr_out
);

	localparam int MSB = datapath_pkg::WORD_W - 1;

	assign and_out = a & b;
	assign or_out  = a | b;
	assign not_out = ~a;
	assign shl_out = {a[MSB-1:0], 1'b0};
	assign shr_out = {a[MSB], a[MSB:1]}; // Sign bit copied down

endmodule

`default_nettype wire

//--- common/datapath_pkg.sv
`default_nettype none

package datapath_pkg;

	localparam int WORD_W   = 16;
	localparam int NUM_REGS = 4;

	typedef logic [WORD_W-1:0]           word_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

	typedef struct packed {
		isa_pkg::opcode_t opcode;
		isa_pkg::func_t   func;
	} alu_ctrl_t;

	typedef struct packed {
		logic     en;
		reg_idx_t dst;
		word_t    data;
	} wb_t;

	typedef struct packed {
		word_t result;
		logic  overflow;
		logic  bcond;
	} exec_out_t;

endpackage

`default_nettype wire

//--- common/isa_pkg.sv
`default_nettype none

package isa_pkg;

	localparam int INSTR_W     = 16;
	localparam int OPCODE_W    = 4;
	localparam int FUNC_W      = 6;
	localparam int REG_FIELD_W = 2;
	localparam int IMM_W       = 8;
	localparam int TARGET_W    = 12;

	// Low bit of each field within the instruction word
	localparam int OPCODE_LSB = 12;
	localparam int RS_LSB     = 10;
	localparam int RT_LSB     = 8;
	localparam int RD_LSB     = 6;
	localparam int FUNC_LSB   = 0;
	localparam int IMM_LSB    = 0;
	localparam int TARGET_LSB = 0;

	typedef logic [OPCODE_W-1:0] opcode_t;
	typedef logic [FUNC_W-1:0]   func_t;
	typedef logic [INSTR_W-1:0]  instr_t;

	localparam opcode_t OP_BNE   = 4'd0;
	localparam opcode_t OP_BEQ   = 4'd1;
	localparam opcode_t OP_BGZ   = 4'd2;
	localparam opcode_t OP_BLZ   = 4'd3;
	localparam opcode_t OP_ADI   = 4'd4;
	localparam opcode_t OP_ORI   = 4'd5;
	localparam opcode_t OP_LHI   = 4'd6;
	localparam opcode_t OP_LWD   = 4'd7;
	localparam opcode_t OP_SWD   = 4'd8;
	localparam opcode_t OP_JMP   = 4'd9;
	localparam opcode_t OP_JAL   = 4'd10;
	localparam opcode_t OP_RTYPE = 4'd15;

	localparam func_t FN_ADD = 6'd0;
	localparam func_t FN_SUB = 6'd1;
	localparam func_t FN_AND = 6'd2;
	localparam func_t FN_ORR = 6'd3;
	localparam func_t FN_NOT = 6'd4;
	localparam func_t FN_TCP = 6'd5;
	localparam func_t FN_SHL = 6'd6;
	localparam func_t FN_SHR = 6'd7;
	localparam func_t FN_JPR = 6'd25;
	localparam func_t FN_JRL = 6'd26;

	localparam logic [REG_FIELD_W-1:0] LINK_REG = 2'd2; // Return address for JAL and JRL

endpackage

`default_nettype wire

//--- hw/exec_core.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    instr_valid,
	input  isa_pkg::instr_t         instr,
	input  datapath_pkg::word_t     pc_next,
	output datapath_pkg::exec_out_t out,
	output logic                    result_valid,
	output datapath_pkg::wb_t       wb
);

	datapath_pkg::reg_idx_t    rs_idx;
	datapath_pkg::reg_idx_t    rt_idx;
	datapath_pkg::word_t       rs_data;
	datapath_pkg::word_t       rt_data;
	datapath_pkg::alu_ctrl_t   alu_ctrl;
	datapath_pkg::word_t       operand_a;
	datapath_pkg::word_t       operand_b;
	logic                      pass_a;
	logic                      pass_b;
	logic                      wr_en;
	datapath_pkg::reg_idx_t    wr_dst;
	datapath_pkg::exec_out_t   alu_out;
	datapath_pkg::wb_t         wr_now;

	instr_decode decode_i (
		.instr     (instr),
		.pc_next   (pc_next),
		.rs_data   (rs_data),
		.rt_data   (rt_data),
		.rs_idx    (rs_idx),
		.rt_idx    (rt_idx),
		.ctrl      (alu_ctrl),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.pass_a    (pass_a),
		.pass_b    (pass_b),
		.wr_en     (wr_en),
		.wr_dst    (wr_dst)
	);

	assign wr_now = '{en: wr_en & instr_valid, dst: wr_dst, data: alu_out.result};

	reg_file regs_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rs_idx  (rs_idx),
		.rt_idx  (rt_idx),
		.rs_data (rs_data),
		.rt_data (rt_data),
		.wr      (wr_now)
	);

	alu alu_i (
		.ctrl   (alu_ctrl),
		.a      (operand_a),
		.b      (operand_b),
		.pass_a (pass_a),
		.pass_b (pass_b),
		.out    (alu_out)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out          <= '0;
			result_valid <= 1'b0;
			wb           <= '0;
		end else begin
			result_valid <= instr_valid;
			wb           <= wr_now; // Mirrors the register file write
			if (instr_valid) begin
				out <= alu_out;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input  isa_pkg::instr_t          instr,
	input  datapath_pkg::word_t      pc_next,
	input  datapath_pkg::word_t      rs_data,
	input  datapath_pkg::word_t      rt_data,
	output datapath_pkg::reg_idx_t   rs_idx,
	output datapath_pkg::reg_idx_t   rt_idx,
	output datapath_pkg::alu_ctrl_t  ctrl,
	output datapath_pkg::word_t      operand_a,
	output datapath_pkg::word_t      operand_b,
	output logic                     pass_a,
	output logic                     pass_b,
	output logic                     wr_en,
	output datapath_pkg::reg_idx_t   wr_dst
);

	localparam int WORD_W = datapath_pkg::WORD_W;
	localparam int EXT_W  = WORD_W - isa_pkg::IMM_W;
	localparam int PC_HI_W = WORD_W - isa_pkg::TARGET_W;

	isa_pkg::opcode_t                 opcode;
	isa_pkg::func_t                   func;
	datapath_pkg::reg_idx_t           rd;
	logic [isa_pkg::IMM_W-1:0]        imm;
	logic [isa_pkg::TARGET_W-1:0]     target;
	datapath_pkg::word_t              imm_sext;
	datapath_pkg::word_t              imm_zext;
	datapath_pkg::word_t              imm_upper;
	datapath_pkg::word_t              jmp_addr;
	logic                             is_link;

	assign opcode = instr[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
	assign func   = instr[isa_pkg::FUNC_LSB +: isa_pkg::FUNC_W];
	assign rs_idx = instr[isa_pkg::RS_LSB +: isa_pkg::REG_FIELD_W];
	assign rt_idx = instr[isa_pkg::RT_LSB +: isa_pkg::REG_FIELD_W];
	assign rd     = instr[isa_pkg::RD_LSB +: isa_pkg::REG_FIELD_W];
	assign imm    = instr[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];
	assign target = instr[isa_pkg::TARGET_LSB +: isa_pkg::TARGET_W];

	assign imm_sext  = {{EXT_W{imm[isa_pkg::IMM_W-1]}}, imm};
	assign imm_zext  = {{EXT_W{1'b0}}, imm};
	assign imm_upper = {imm, {EXT_W{1'b0}}};
	assign jmp_addr  = {pc_next[WORD_W-1 -: PC_HI_W], target}; // Stays in current region

	assign ctrl = '{opcode: opcode, func: func};

	assign is_link = (opcode == isa_pkg::OP_JAL) ||
		((opcode == isa_pkg::OP_RTYPE) && (func == isa_pkg::FN_JRL));

	assign operand_a = is_link ? pc_next : rs_data;
	assign pass_a    = (opcode == isa_pkg::OP_JAL);
	assign pass_b    = (opcode == isa_pkg::OP_JAL); // Fallback to target if pc path is off

	always_comb begin
		case (opcode)
			isa_pkg::OP_ADI, isa_pkg::OP_LWD, isa_pkg::OP_SWD: operand_b = imm_sext;
			isa_pkg::OP_ORI: operand_b = imm_zext;
			isa_pkg::OP_LHI: operand_b = imm_upper;
			isa_pkg::OP_JMP, isa_pkg::OP_JAL: operand_b = jmp_addr;
			default: operand_b = rt_data;
		endcase
	end

	always_comb begin
		wr_en  = 1'b0;
		wr_dst = rd;
		case (opcode)
			isa_pkg::OP_RTYPE: begin
				if (func <= isa_pkg::FN_SHR) begin
					wr_en = 1'b1;
				end else if (func == isa_pkg::FN_JRL) begin
					wr_en  = 1'b1;
					wr_dst = isa_pkg::LINK_REG;
				end
			end
			isa_pkg::OP_ADI, isa_pkg::OP_ORI, isa_pkg::OP_LHI: begin
				wr_en  = 1'b1;
				wr_dst = rt_idx;
			end
			isa_pkg::OP_JAL: begin
				wr_en  = 1'b1;
				wr_dst = isa_pkg::LINK_REG;
			end
			default: wr_en = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  logic                   clk,
	input  logic                   rst_n,
	input  datapath_pkg::reg_idx_t rs_idx,
	input  datapath_pkg::reg_idx_t rt_idx,
	output datapath_pkg::word_t    rs_data,
	output datapath_pkg::word_t    rt_data,
	input  datapath_pkg::wb_t      wr
);

	datapath_pkg::word_t regs [datapath_pkg::NUM_REGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < datapath_pkg::NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr.en) begin
			regs[wr.dst] <= wr.data;
		end
	end

	// Next instruction arrives after the write edge
	assign rs_data = regs[rs_idx];
	assign rt_data = regs[rt_idx];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_core_tb -f vlog.f -o exec_core_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output="$(./obj_dir/exec_core_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi
exit 1

//--- sim/exec_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_chk (
	input logic                    clk,
	input logic                    rst_n,
	input logic                    instr_valid,
	input logic                    result_valid,
	input datapath_pkg::exec_out_t out,
	input datapath_pkg::wb_t       wb
);

	int failures = 0; // Read by the testbench at the end of the run

	a_reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !result_valid)
		else begin
			failures++;
			$error("result_valid high in the cycle after reset");
		end

	a_write_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
		wb.en |-> result_valid)
		else begin
			failures++;
			$error("wb.en high without result_valid");
		end

	// Branches never overflow and arithmetic never sets bcond
	a_flags_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(out.overflow && out.bcond))
		else begin
			failures++;
			$error("overflow and bcond high together");
		end

	a_valid_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		!instr_valid |=> !result_valid)
		else begin
			failures++;
			$error("result_valid held after an idle cycle");
		end

endmodule

`default_nettype wire

//--- sim/exec_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

	localparam int MAX_CYCLES = 600; // Tests take about 110 cycles, wide margin

	logic                    clk;
	logic                    rst_n;
	logic                    instr_valid;
	isa_pkg::instr_t         instr;
	datapath_pkg::word_t     pc_next;
	datapath_pkg::exec_out_t out;
	logic                    result_valid;
	datapath_pkg::wb_t       wb;

	datapath_pkg::word_t model_regs [datapath_pkg::NUM_REGS];
	datapath_pkg::exec_out_t last_out = '0; // Held by the DUT while idle
	int seed        = 87;
	int cycles      = 0;
	int check_count = 0;
	int error_count = 0;
	int test_count  = 0;
	int clean_count = 0;

	exec_core exec_core_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.pc_next      (pc_next),
		.out          (out),
		.result_valid (result_valid),
		.wb           (wb)
	);

	bind exec_core exec_core_chk chk_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.instr_valid  (instr_valid),
		.result_valid (result_valid),
		.out          (out),
		.wb           (wb)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic isa_pkg::instr_t r_word(input logic [1:0] rs, input logic [1:0] rt,
			input logic [1:0] rd, input isa_pkg::func_t fn);
		return {isa_pkg::OP_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic isa_pkg::instr_t i_word(input isa_pkg::opcode_t op,
			input logic [1:0] rs, input logic [1:0] rt, input logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic isa_pkg::instr_t j_word(input isa_pkg::opcode_t op,
			input logic [11:0] target);
		return {op, target};
	endfunction

	function automatic logic out_of_range(input int wide);
		return (wide > 32767) || (wide < -32768); // Signed 16-bit range
	endfunction

	task automatic mismatch(input string name, input datapath_pkg::word_t expected,
			input datapath_pkg::word_t actual);
		error_count++;
		$display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
	endtask

	task automatic fault(input string what);
		error_count++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic predict(input isa_pkg::instr_t ins, input datapath_pkg::word_t pc,
			output datapath_pkg::exec_out_t eo, output datapath_pkg::wb_t ew);
		datapath_pkg::word_t rs;
		datapath_pkg::word_t rt;
		datapath_pkg::word_t imm_s;
		int wide;
		rs    = model_regs[ins[11:10]];
		rt    = model_regs[ins[9:8]];
		imm_s = {{8{ins[7]}}, ins[7:0]};
		eo    = '0;
		ew    = '0;
		case (ins[15:12])
			isa_pkg::OP_RTYPE: begin
				ew.en  = 1'b1;
				ew.dst = ins[7:6];
				case (ins[5:0])
					isa_pkg::FN_ADD: begin
						eo.result   = rs + rt;
						wide        = int'($signed(rs)) + int'($signed(rt));
						eo.overflow = out_of_range(wide);
					end
					isa_pkg::FN_SUB: begin
						eo.result   = rs - rt;
						wide        = int'($signed(rs)) - int'($signed(rt));
						eo.overflow = out_of_range(wide);
					end
					isa_pkg::FN_AND: eo.result = rs & rt;
					isa_pkg::FN_ORR: eo.result = rs | rt;
					isa_pkg::FN_NOT: eo.result = ~rs;
					isa_pkg::FN_TCP: eo.result = -rs;
					isa_pkg::FN_SHL: eo.result = rs << 1;
					isa_pkg::FN_SHR: eo.result = $signed(rs) >>> 1;
					isa_pkg::FN_JPR: begin
						eo.result = rs;
						ew.en     = 1'b0;
					end
					isa_pkg::FN_JRL: begin
						eo.result = pc; // Link address
						ew.dst    = isa_pkg::LINK_REG;
					end
					default: ew.en = 1'b0;
				endcase
			end
			isa_pkg::OP_BNE: eo.bcond = (rs != rt);
			isa_pkg::OP_BEQ: eo.bcond = (rs == rt);
			isa_pkg::OP_BGZ: eo.bcond = ($signed(rs) > 16'sd0);
			isa_pkg::OP_BLZ: eo.bcond = ($signed(rs) < 16'sd0);
			isa_pkg::OP_ADI, isa_pkg::OP_LWD, isa_pkg::OP_SWD: begin
				eo.result   = rs + imm_s;
				wide        = int'($signed(rs)) + int'($signed(imm_s));
				eo.overflow = out_of_range(wide);
				ew.en       = (ins[15:12] == isa_pkg::OP_ADI);
				ew.dst      = ins[9:8];
			end
			isa_pkg::OP_ORI: begin
				eo.result = rs | {8'h00, ins[7:0]};
				ew.en     = 1'b1;
				ew.dst    = ins[9:8];
			end
			isa_pkg::OP_LHI: begin
				eo.result = {ins[7:0], 8'h00};
				ew.en     = 1'b1;
				ew.dst    = ins[9:8];
			end
			isa_pkg::OP_JMP: eo.result = {pc[15:12], ins[11:0]};
			isa_pkg::OP_JAL: begin
				eo.result = pc;
				ew.en     = 1'b1;
				ew.dst    = isa_pkg::LINK_REG;
			end
			default: ;
		endcase
		ew.data = eo.result;
	endtask

	// Leaves instr_valid high so that calls in a row run back to back
	task automatic issue(input isa_pkg::instr_t ins, input datapath_pkg::word_t pc);
		datapath_pkg::exec_out_t exp_out;
		datapath_pkg::wb_t       exp_wb;
		predict(ins, pc, exp_out, exp_wb);
		instr       = ins;
		pc_next     = pc;
		instr_valid = 1'b1;
		@(posedge clk);
		#1;
		check_count++;
		if (result_valid !== 1'b1) fault("result_valid low one cycle after issue");
		if (out.result !== exp_out.result) mismatch("out.result", exp_out.result, out.result);
		if (out.overflow !== exp_out.overflow) begin
			mismatch("out.overflow", 16'(exp_out.overflow), 16'(out.overflow));
		end
		if (out.bcond !== exp_out.bcond) begin
			mismatch("out.bcond", 16'(exp_out.bcond), 16'(out.bcond));
		end
		if (wb.en !== exp_wb.en) mismatch("wb.en", 16'(exp_wb.en), 16'(wb.en));
		if (exp_wb.en && (wb.dst !== exp_wb.dst)) begin
			mismatch("wb.dst", 16'(exp_wb.dst), 16'(wb.dst));
		end
		if (exp_wb.en && (wb.data !== exp_wb.data)) mismatch("wb.data", exp_wb.data, wb.data);
		if (exp_wb.en) model_regs[exp_wb.dst] = exp_wb.data;
		last_out = exp_out;
	endtask

	task automatic idle(input int n);
		instr_valid = 1'b0;
		repeat (n) @(posedge clk);
		#1;
		check_count++;
		if (result_valid !== 1'b0) fault("result_valid high while idle");
		if (wb.en !== 1'b0) fault("wb.en high while idle");
		if (out.result !== last_out.result) begin
			mismatch("out.result", last_out.result, out.result);
		end
		if (out.overflow !== last_out.overflow || out.bcond !== last_out.bcond) begin
			fault("flags changed while idle");
		end
	endtask

	task automatic load_reg(input logic [1:0] r, input datapath_pkg::word_t value);
		issue(i_word(isa_pkg::OP_LHI, r, r, value[15:8]), 16'h0100);
		issue(i_word(isa_pkg::OP_ORI, r, r, value[7:0]), 16'h0100);
	endtask

	task automatic end_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before) begin
			clean_count++;
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	task automatic reset_and_idle();
		int e;
		e = error_count;
		idle(4);
		check_count++;
		if (out.result !== 16'h0000) mismatch("out.result", 16'h0000, out.result);
		if (out.overflow !== 1'b0 || out.bcond !== 1'b0) fault("flags set after reset");
		for (int r = 0; r < datapath_pkg::NUM_REGS; r++) begin
			issue(r_word(2'(r), 2'(r), 2'(r), isa_pkg::FN_ORR), 16'h0010);
		end
		idle(1);
		end_test("reset and idle", e);
	endtask

	task automatic loads_and_arith();
		int e;
		e = error_count;
		load_reg(2'd0, 16'h1234);
		load_reg(2'd1, 16'h7FFF);
		load_reg(2'd2, 16'h8000);
		load_reg(2'd3, 16'h0001);
		issue(r_word(2'd1, 2'd3, 2'd0, isa_pkg::FN_ADD), 16'h0100); // 0x7FFF + 1
		issue(r_word(2'd2, 2'd3, 2'd1, isa_pkg::FN_SUB), 16'h0100); // 0x8000 - 1
		issue(r_word(2'd3, 2'd3, 2'd3, isa_pkg::FN_ADD), 16'h0100);
		issue(r_word(2'd1, 2'd3, 2'd2, isa_pkg::FN_SUB), 16'h0100);
		issue(i_word(isa_pkg::OP_ADI, 2'd3, 2'd0, 8'hFB), 16'h0100);
		issue(r_word(2'd0, 2'd0, 2'd2, isa_pkg::FN_TCP), 16'h0100);
		idle(1);
		end_test("loads and arithmetic", e);
	endtask

	task automatic logic_and_shifts();
		int e;
		e = error_count;
		load_reg(2'd0, 16'hA55A);
		load_reg(2'd1, 16'h0FF0);
		issue(r_word(2'd0, 2'd1, 2'd2, isa_pkg::FN_AND), 16'h0100);
		issue(r_word(2'd0, 2'd1, 2'd3, isa_pkg::FN_ORR), 16'h0100);
		issue(r_word(2'd1, 2'd0, 2'd2, isa_pkg::FN_NOT), 16'h0100);
		issue(r_word(2'd0, 2'd0, 2'd3, isa_pkg::FN_SHL), 16'h0100);
		issue(r_word(2'd0, 2'd0, 2'd2, isa_pkg::FN_SHR), 16'h0100); // Negative source
		issue(r_word(2'd1, 2'd0, 2'd3, isa_pkg::FN_SHR), 16'h0100);
		idle(1);
		end_test("logic and shifts", e);
	endtask

	task automatic branches();
		int e;
		e = error_count;
		load_reg(2'd0, 16'h0005);
		load_reg(2'd1, 16'h0005);
		load_reg(2'd2, 16'hFFF0);
		load_reg(2'd3, 16'h0000);
		issue(i_word(isa_pkg::OP_BEQ, 2'd0, 2'd1, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BEQ, 2'd0, 2'd2, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BNE, 2'd0, 2'd1, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BNE, 2'd0, 2'd2, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BGZ, 2'd0, 2'd0, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BGZ, 2'd3, 2'd0, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BGZ, 2'd2, 2'd0, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BLZ, 2'd0, 2'd0, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BLZ, 2'd3, 2'd0, 8'h04), 16'h0100);
		issue(i_word(isa_pkg::OP_BLZ, 2'd2, 2'd0, 8'h04), 16'h0100);
		idle(1);
		end_test("branches", e);
	endtask

	task automatic jumps_and_addresses();
		int e;
		e = error_count;
		load_reg(2'd1, 16'h2000);
		issue(j_word(isa_pkg::OP_JMP, 12'h456), 16'hA123);
		issue(j_word(isa_pkg::OP_JAL, 12'h020), 16'h3004);
		issue(r_word(2'd1, 2'd0, 2'd0, isa_pkg::FN_JRL), 16'h4002);
		issue(r_word(2'd1, 2'd0, 2'd0, isa_pkg::FN_JPR), 16'h4004);
		issue(i_word(isa_pkg::OP_LWD, 2'd1, 2'd0, 8'h08), 16'h4006);
		issue(i_word(isa_pkg::OP_SWD, 2'd1, 2'd3, 8'hFC), 16'h4008); // Negative offset
		idle(1);
		end_test("jumps and addresses", e);
	endtask

	task automatic random_stream();
		logic [31:0]      r;
		logic [3:0]       sel;
		isa_pkg::opcode_t op;
		int               e;
		e = error_count;
		for (int n = 0; n < 40; n++) begin
			r   = $random(seed);
			sel = r[3:0] % 4'd11; // 0..7 R-type, 8..10 I-type
			if (sel < 4'd8) begin
				issue(r_word(r[5:4], r[7:6], r[9:8], isa_pkg::func_t'(sel)), 16'h0200);
			end else begin
				op = (sel == 4'd8) ? isa_pkg::OP_ADI :
					((sel == 4'd9) ? isa_pkg::OP_ORI : isa_pkg::OP_LHI);
				issue(i_word(op, r[5:4], r[7:6], r[17:10]), 16'h0200);
			end
		end
		idle(1);
		end_test("random back-to-back stream", e);
	endtask

	initial begin
		instr_valid = 1'b0;
		instr       = '0;
		pc_next     = '0;
		rst_n       = 1'b0;
		for (int i = 0; i < datapath_pkg::NUM_REGS; i++) begin
			model_regs[i] = '0;
		end
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_and_idle();
		loads_and_arith();
		logic_and_shifts();
		branches();
		jumps_and_addresses();
		random_stream();
		error_count = error_count + exec_core_i.chk_i.failures; // Assertion failures
		$display("tests %0d, clean %0d, checks %0d, errors %0d",
			test_count, clean_count, check_count, error_count);
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/isa_pkg.sv
common/datapath_pkg.sv
alu/alu_arith.sv
alu/alu_logic.sv
alu/alu.sv
hw/instr_decode.sv
hw/reg_file.sv
hw/exec_core.sv
sim/exec_core_chk.sv
sim/exec_core_tb.sv
